// File: verilog/icache_defs.svh
/*
 * instruction cache geometry
 * address split, way count and bus widths shared by the RTL and the testbench
 */

`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// physical fetch address
`define ICACHE_PADDR_W 32

// four ways of 64 sets, 16 byte lines
`define ICACHE_WAYS 4
`define ICACHE_SETS 64
`define ICACHE_LINE_W 128
`define ICACHE_FETCH_W 32

// paddr = {tag, index, offset}
`define ICACHE_OFFSET_W 4
`define ICACHE_INDEX_W 6
`define ICACHE_TAG_W 22

// upper half of the address space is I/O, never cached
`define ICACHE_NC_BIT 31

`endif

// File: verilog/icache_pkg.sv
/*
 * instruction cache types
 * controller state and the packed structs carried on the cache ports
 */

`include "icache_defs.svh"

package icache_pkg;

  // controller states
  typedef enum logic [1:0] {
    FLUSH,
    IDLE,
    READ,
    MISS
  } ctrl_state_e;

  // fetch request, physical address only
  typedef struct packed {
    logic [`ICACHE_PADDR_W-1:0] paddr;
  } fetch_req_t;

  // fetch response, word plus the word aligned address it came from
  typedef struct packed {
    logic [`ICACHE_FETCH_W-1:0] data;
    logic [`ICACHE_PADDR_W-1:0] paddr;
  } fetch_rsp_t;

  // refill request, line address or word address when nc is set
  typedef struct packed {
    logic [`ICACHE_PADDR_W-1:0] paddr;
    logic                       nc;
  } mem_req_t;

  // refill return, always a full line
  typedef struct packed {
    logic [`ICACHE_LINE_W-1:0] data;
  } mem_rtrn_t;

  // array commands from the controller
  typedef struct packed {
    logic                       rd_en;
    logic                       wr_en;
    logic                       flush_en;
    logic [`ICACHE_INDEX_W-1:0] index;
    // tag of the fetch in flight, used for compare and refill
    logic [`ICACHE_TAG_W-1:0]   tag;
  } array_ctrl_t;

endpackage

// File: verilog/icache_ctrl.sv
/*
 * instruction cache controller
 * FSM for flush, lookup and refill, plus the fetch address latch
 * and the non-cacheable decision
 */

`include "icache_defs.svh"

module icache_ctrl import icache_pkg::*; (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        en_i,
  input  logic                        flush_i,
  input  logic                        fetch_valid_i,
  input  fetch_req_t                  fetch_req_i,
  input  logic                        hit_i,
  input  logic                        mem_ack_i,
  input  logic                        mem_rtrn_vld_i,
  output logic                        fetch_ready_o,
  output logic                        rsp_valid_o,
  output logic [`ICACHE_PADDR_W-1:0]  rsp_paddr_o,
  output logic                        miss_o,
  output logic                        mem_req_o,
  output mem_req_t                    mem_req_data_o,
  output array_ctrl_t                 array_ctrl_o,
  output logic                        cmp_en_o,
  output logic [`ICACHE_OFFSET_W-1:0] offset_o
);

  localparam int IDX_LO = `ICACHE_OFFSET_W;
  localparam int IDX_HI = `ICACHE_OFFSET_W + `ICACHE_INDEX_W - 1;

  ctrl_state_e                state_d, state_q;
  logic                       cache_en_d, cache_en_q;
  logic                       flush_d, flush_q;
  logic [`ICACHE_INDEX_W-1:0] flush_cnt_q;
  logic                       flush_en, flush_done;
  logic                       accept, wr_en, nc_in;
  // latched fetch, nc flag and compare enable for the next cycle
  logic [`ICACHE_PADDR_W-1:0] paddr_q;
  logic                       nc_q;
  logic                       cmp_en_q;

  assign accept = fetch_ready_o & fetch_valid_i;
  // I/O space or cache off both fall back to single word fetches
  assign nc_in  = ~cache_en_q | fetch_req_i.paddr[`ICACHE_NC_BIT];

  assign flush_done = (flush_cnt_q == `ICACHE_INDEX_W'(`ICACHE_SETS - 1));

  ////////////////////////////////////////////////////////////
  // main FSM
  ////////////////////////////////////////////////////////////
  always_comb begin
    state_d       = state_q;
    // turning off is immediate, turning on goes through FLUSH
    cache_en_d    = cache_en_q & en_i;
    flush_d       = flush_q | flush_i;
    flush_en      = 1'b0;
    wr_en         = 1'b0;
    fetch_ready_o = 1'b0;
    rsp_valid_o   = 1'b0;
    mem_req_o     = 1'b0;
    miss_o        = 1'b0;

    unique case (state_q)
      // walk all sets and clear the valid bits
      FLUSH: begin
        flush_en = 1'b1;
        if (flush_done) begin
          state_d    = IDLE;
          flush_d    = 1'b0;
          cache_en_d = en_i;
        end
      end
      // pending flush or a fresh enable wins over new fetches
      IDLE: begin
        if (flush_d || (en_i && !cache_en_q)) begin
          state_d = FLUSH;
        end else begin
          fetch_ready_o = 1'b1;
          if (fetch_valid_i) begin
            state_d = READ;
          end
        end
      end
      // array data is out, answer a hit or go to memory
      READ: begin
        if (hit_i) begin
          rsp_valid_o = 1'b1;
          state_d     = IDLE;
          // stream the next fetch unless a flush waits
          if (!flush_d) begin
            fetch_ready_o = 1'b1;
            if (fetch_valid_i) begin
              state_d = READ;
            end
          end
        end else begin
          mem_req_o = 1'b1;
          if (mem_ack_i) begin
            miss_o  = ~nc_q;
            state_d = MISS;
          end
        end
      end
      // return is consumed unconditionally
      MISS: begin
        if (mem_rtrn_vld_i) begin
          rsp_valid_o = 1'b1;
          wr_en       = ~nc_q;
          state_d     = IDLE;
        end
      end
      default: begin
        state_d = FLUSH;
      end
    endcase
  end

  // array index: flush walk, new fetch, or the latched fetch for refill
  assign array_ctrl_o.rd_en    = accept;
  assign array_ctrl_o.wr_en    = wr_en;
  assign array_ctrl_o.flush_en = flush_en;
  assign array_ctrl_o.index    = flush_en ? flush_cnt_q :
                                 accept   ? fetch_req_i.paddr[IDX_HI:IDX_LO] :
                                            paddr_q[IDX_HI:IDX_LO];
  assign array_ctrl_o.tag      = paddr_q[`ICACHE_PADDR_W-1:IDX_HI+1];

  assign cmp_en_o    = cmp_en_q;
  assign offset_o    = paddr_q[`ICACHE_OFFSET_W-1:0];
  assign rsp_paddr_o = {paddr_q[`ICACHE_PADDR_W-1:2], 2'b00};

  // word address for nc, line address otherwise
  assign mem_req_data_o.nc    = nc_q;
  assign mem_req_data_o.paddr = nc_q ?
      {paddr_q[`ICACHE_PADDR_W-1:2], 2'b00} :
      {paddr_q[`ICACHE_PADDR_W-1:IDX_LO], {`ICACHE_OFFSET_W{1'b0}}};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= FLUSH;
      cache_en_q  <= 1'b0;
      flush_q     <= 1'b0;
      flush_cnt_q <= '0;
      nc_q        <= 1'b0;
      cmp_en_q    <= 1'b0;
    end else begin
      state_q     <= state_d;
      cache_en_q  <= cache_en_d;
      flush_q     <= flush_d;
      flush_cnt_q <= flush_done ? '0 : flush_cnt_q + `ICACHE_INDEX_W'(flush_en);
      // compare only for cacheable fetches, one cycle after accept
      cmp_en_q    <= accept & ~nc_in;
      if (accept) begin
        nc_q <= nc_in;
      end
    end
  end

  // fetch address, payload only
  always_ff @(posedge clk_i) begin
    if (accept) begin
      paddr_q <= fetch_req_i.paddr;
    end
  end

  ////////////////////////////////////////////////////////////
  // assertions
  ////////////////////////////////////////////////////////////
  state_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(state_q) && (state_q inside {FLUSH, IDLE, READ, MISS}))
    else $error("icache ctrl: illegal state");

endmodule

// File: verilog/icache_lookup.sv
/*
 * instruction cache lookup
 * tag compare, word select, hit/refill data mux and replacement choice
 */

`include "icache_defs.svh"

module icache_lookup import icache_pkg::*; (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  array_ctrl_t                                   array_ctrl_i,
  input  logic                                          cmp_en_i,
  input  logic [`ICACHE_OFFSET_W-1:0]                   offset_i,
  input  logic [`ICACHE_WAYS-1:0][`ICACHE_TAG_W-1:0]    tag_rdata_i,
  input  logic [`ICACHE_WAYS-1:0]                       vld_rdata_i,
  input  logic [`ICACHE_WAYS-1:0][`ICACHE_LINE_W-1:0]   line_rdata_i,
  input  mem_rtrn_t                                     mem_rtrn_i,
  output logic                                          hit_o,
  output logic [`ICACHE_WAYS-1:0]                       repl_way_o,
  output logic [`ICACHE_FETCH_W-1:0]                    data_o
);

  localparam int WAY_IDX_W = $clog2(`ICACHE_WAYS);

  logic [`ICACHE_WAYS-1:0]    hit_vec;
  logic [`ICACHE_FETCH_W-1:0] hit_word;
  // bit position of the fetched word inside a line
  logic [6:0]                 word_sel;
  logic [`ICACHE_WAYS-1:0]    inv_oh, rnd_oh;
  logic                       all_valid;
  logic [7:0]                 lfsr_q;

  assign word_sel = {offset_i[`ICACHE_OFFSET_W-1:2], 5'b00000};

  ////////////////////////////////////////////////////////////
  // tag compare and word select
  ////////////////////////////////////////////////////////////
  always_comb begin
    hit_word = '0;
    for (int i = 0; i < `ICACHE_WAYS; i++) begin
      hit_vec[i] = vld_rdata_i[i] & (tag_rdata_i[i] == array_ctrl_i.tag);
      // and-or mux, hit_vec is at most one-hot
      hit_word |= {`ICACHE_FETCH_W{hit_vec[i]}} & line_rdata_i[i][word_sel +: `ICACHE_FETCH_W];
    end
  end

  assign hit_o  = cmp_en_i & (|hit_vec);
  // refill and nc data come straight from the return line
  assign data_o = cmp_en_i ? hit_word : mem_rtrn_i.data[word_sel +: `ICACHE_FETCH_W];

  ////////////////////////////////////////////////////////////
  // replacement
  ////////////////////////////////////////////////////////////
  // lowest invalid way
  always_comb begin
    logic found;
    found  = 1'b0;
    inv_oh = '0;
    for (int i = 0; i < `ICACHE_WAYS; i++) begin
      if (!vld_rdata_i[i] && !found) begin
        inv_oh[i] = 1'b1;
        found     = 1'b1;
      end
    end
  end

  assign all_valid = &vld_rdata_i;
  assign rnd_oh    = `ICACHE_WAYS'(1) << lfsr_q[WAY_IDX_W-1:0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      repl_way_o <= '0;
      lfsr_q     <= 8'ha5;
    end else begin
      // pick the victim while the set is being compared
      if (cmp_en_i) begin
        repl_way_o <= all_valid ? rnd_oh : inv_oh;
      end
      // x^8 + x^6 + x^5 + x^4 + 1, steps only on random replacement
      if (array_ctrl_i.wr_en && all_valid) begin
        lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
      end
    end
  end

  // two ways holding the same tag means a refill duplicated a line
  hit_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmp_en_i |-> $onehot0(hit_vec))
    else $error("icache lookup: multiple ways hit");

endmodule

// File: verilog/icache_arrays.sv
/*
 * instruction cache arrays
 * per-way valid bits, tags and lines, read with one cycle latency
 */

`include "icache_defs.svh"

module icache_arrays import icache_pkg::*; (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  array_ctrl_t                                   array_ctrl_i,
  input  logic [`ICACHE_WAYS-1:0]                       repl_way_i,
  input  mem_rtrn_t                                     wdata_i,
  output logic [`ICACHE_WAYS-1:0][`ICACHE_TAG_W-1:0]    tag_rdata_o,
  output logic [`ICACHE_WAYS-1:0]                       vld_rdata_o,
  output logic [`ICACHE_WAYS-1:0][`ICACHE_LINE_W-1:0]   line_rdata_o
);

  for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : gen_way
    logic [`ICACHE_TAG_W-1:0]  tag_mem  [`ICACHE_SETS];
    logic [`ICACHE_LINE_W-1:0] line_mem [`ICACHE_SETS];
    logic [`ICACHE_SETS-1:0]   vld_mem;
    logic [`ICACHE_TAG_W-1:0]  tag_q;
    logic [`ICACHE_LINE_W-1:0] line_q;
    logic                      vld_q;

    // flush clears the whole set, refill fills only the victim way
    always_ff @(posedge clk_i) begin
      if (array_ctrl_i.flush_en) begin
        vld_mem[array_ctrl_i.index] <= 1'b0;
      end else if (array_ctrl_i.wr_en && repl_way_i[w]) begin
        vld_mem[array_ctrl_i.index]  <= 1'b1;
        tag_mem[array_ctrl_i.index]  <= array_ctrl_i.tag;
        line_mem[array_ctrl_i.index] <= wdata_i.data;
      end
      if (array_ctrl_i.rd_en) begin
        tag_q  <= tag_mem[array_ctrl_i.index];
        line_q <= line_mem[array_ctrl_i.index];
      end
    end

    // valid readout feeds hit and victim choice, keep it clean after reset
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        vld_q <= 1'b0;
      end else if (array_ctrl_i.rd_en) begin
        vld_q <= vld_mem[array_ctrl_i.index];
      end
    end

    assign tag_rdata_o[w]  = tag_q;
    assign line_rdata_o[w] = line_q;
    assign vld_rdata_o[w]  = vld_q;
  end

  // controller never refills while walking the flush
  no_wr_during_flush: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(array_ctrl_i.wr_en && array_ctrl_i.flush_en))
    else $error("icache arrays: write during flush");

endmodule

// File: verilog/icache_top.sv
/*
 * four-way set-associative instruction cache
 * fetch port with ready/valid, line refill port with req/ack
 */

`include "icache_defs.svh"

module icache_top import icache_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       en_i,
  input  logic       flush_i,
  output logic       miss_o,
  // fetch side
  input  logic       fetch_valid_i,
  input  fetch_req_t fetch_req_i,
  output logic       fetch_ready_o,
  output logic       rsp_valid_o,
  output fetch_rsp_t fetch_rsp_o,
  // refill side
  output logic       mem_req_o,
  output mem_req_t   mem_req_data_o,
  input  logic       mem_ack_i,
  input  logic       mem_rtrn_vld_i,
  input  mem_rtrn_t  mem_rtrn_i
);

  array_ctrl_t                               array_ctrl;
  logic                                      cmp_en, hit;
  logic [`ICACHE_OFFSET_W-1:0]               offset;
  logic [`ICACHE_WAYS-1:0]                   repl_way;
  logic [`ICACHE_WAYS-1:0][`ICACHE_TAG_W-1:0]  tag_rdata;
  logic [`ICACHE_WAYS-1:0]                   vld_rdata;
  logic [`ICACHE_WAYS-1:0][`ICACHE_LINE_W-1:0] line_rdata;
  logic [`ICACHE_FETCH_W-1:0]                lookup_data;
  logic [`ICACHE_PADDR_W-1:0]                rsp_paddr;

  icache_ctrl i_ctrl (
    .clk_i, .rst_ni, .en_i, .flush_i, .fetch_valid_i, .fetch_req_i,
    .hit_i          (hit),
    .mem_ack_i, .mem_rtrn_vld_i, .fetch_ready_o, .rsp_valid_o,
    .rsp_paddr_o    (rsp_paddr),
    .miss_o, .mem_req_o, .mem_req_data_o,
    .array_ctrl_o   (array_ctrl),
    .cmp_en_o       (cmp_en),
    .offset_o       (offset)
  );

  icache_lookup i_lookup (
    .clk_i, .rst_ni,
    .array_ctrl_i   (array_ctrl),
    .cmp_en_i       (cmp_en),
    .offset_i       (offset),
    .tag_rdata_i    (tag_rdata),
    .vld_rdata_i    (vld_rdata),
    .line_rdata_i   (line_rdata),
    .mem_rtrn_i,
    .hit_o          (hit),
    .repl_way_o     (repl_way),
    .data_o         (lookup_data)
  );

  // refill line is written straight from the return bus
  icache_arrays i_arrays (
    .clk_i, .rst_ni,
    .array_ctrl_i   (array_ctrl),
    .repl_way_i     (repl_way),
    .wdata_i        (mem_rtrn_i),
    .tag_rdata_o    (tag_rdata),
    .vld_rdata_o    (vld_rdata),
    .line_rdata_o   (line_rdata)
  );

  assign fetch_rsp_o = '{data: lookup_data, paddr: rsp_paddr};

endmodule

// File: test/icache_tb.sv
/*
 * instruction cache testbench
 * directed miss, hit, non-cacheable and flush cases, then a random fetch run
 * against a memory model with random acknowledge and return delays
 */

`include "icache_defs.svh"

module icache_tb import icache_pkg::*; ();

  localparam int NUM_RAND  = 300;
  localparam int NUM_LINES = 12;
  // 12 cycles per fetch (random plus directed), 70 per flush
  localparam int MAX_CYCLES = (NUM_RAND + 20) * 12 + 4 * 70;
  // random lines start at set 0, tag steps of 0x400
  localparam logic [31:0] RAND_BASE = 32'h0002_0000;

  logic       clk_i, rst_ni, en_i, flush_i, miss_o;
  logic       fetch_valid_i, fetch_ready_o, rsp_valid_o;
  fetch_req_t fetch_req_i;
  fetch_rsp_t fetch_rsp_o;
  logic       mem_req_o, mem_ack_i, mem_rtrn_vld_i;
  mem_req_t   mem_req_data_o;
  mem_rtrn_t  mem_rtrn_i;

  // scoreboard state
  logic [31:0] acc_q[$];
  logic [31:0] exp_addr;
  logic [31:0] rtrn_addr;
  mem_req_t    last_req;
  int          acc_cnt, rsp_cnt, req_cnt, miss_cnt;
  int          data_err, proto_err, cycle_cnt;
  int          ack_wait, rtrn_wait;

  icache_top uut (.*);

  initial clk_i = 1'b0;
  always #20 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////
  // memory contents
  ////////////////////////////////////////////////////////////
  // expected word, a fixed hash of the word address
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    logic [31:0] h;
    h = {addr[31:2], 2'b00} ^ 32'h9e37_79b9;
    h = h * 32'h85eb_ca6b;
    h = h ^ (h >> 15);
    h = h * 32'hc2b2_ae35;
    return h ^ (h >> 13);
  endfunction

  // word i of the line sits at bits 32*i
  function automatic logic [`ICACHE_LINE_W-1:0] mem_line(input logic [31:0] addr);
    logic [`ICACHE_LINE_W-1:0] line;
    for (int i = 0; i < 4; i++) begin
      line[32*i +: 32] = mem_word({addr[31:4], 4'b0000} + 32'(4 * i));
    end
    return line;
  endfunction

  // ack after 0-3 extra cycles, line back 1-4 cycles after ack
  always @(posedge clk_i) begin
    mem_ack_i      <= 1'b0;
    mem_rtrn_vld_i <= 1'b0;
    if (rst_ni) begin
      if (mem_req_o && mem_ack_i) begin
        rtrn_addr = mem_req_data_o.paddr;
        rtrn_wait = 1 + $urandom_range(3);
      end else if (mem_req_o) begin
        if (ack_wait < 0) begin
          ack_wait = $urandom_range(3);
        end
        if (ack_wait == 0) begin
          mem_ack_i <= 1'b1;
        end
        ack_wait = ack_wait - 1;
      end
      if (rtrn_wait > 0) begin
        rtrn_wait = rtrn_wait - 1;
        if (rtrn_wait == 0) begin
          mem_rtrn_vld_i <= 1'b1;
          mem_rtrn_i     <= '{data: mem_line(rtrn_addr)};
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // checker
  ////////////////////////////////////////////////////////////
  always @(posedge clk_i) begin
    if (rst_ni) begin
      // pop before push, a streamed hit answers and accepts at one edge
      if (rsp_valid_o) begin
        rsp_cnt++;
        if (acc_q.size() == 0) begin
          $display("error %0t: response arrived with no fetch outstanding", $time);
          proto_err++;
        end else begin
          exp_addr = acc_q.pop_front();
          if (fetch_rsp_o.data !== mem_word(exp_addr)) begin
            $display("error %0t fetch_rsp_o.data got %h expected %h", $time,
                     fetch_rsp_o.data, mem_word(exp_addr));
            data_err++;
          end
          if (fetch_rsp_o.paddr !== {exp_addr[31:2], 2'b00}) begin
            $display("error %0t fetch_rsp_o.paddr got %h expected %h", $time,
                     fetch_rsp_o.paddr, {exp_addr[31:2], 2'b00});
            data_err++;
          end
        end
      end
      if (fetch_valid_i && fetch_ready_o) begin
        acc_q.push_back(fetch_req_i.paddr);
        acc_cnt++;
      end
      if (mem_req_o && mem_ack_i) begin
        req_cnt++;
        last_req = mem_req_data_o;
      end
      if (miss_o) begin
        miss_cnt++;
      end
      // miss pulse only in the ack cycle of a cacheable refill
      if (miss_o !== (mem_req_o && mem_ack_i && !mem_req_data_o.nc)) begin
        $display("error %0t miss_o got %b expected %b", $time, miss_o,
                 mem_req_o && mem_ack_i && !mem_req_data_o.nc);
        proto_err++;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // fetch tasks
  ////////////////////////////////////////////////////////////
  // returns at the accepting edge with valid already dropped
  task automatic fetch_word(input logic [31:0] addr);
    fetch_valid_i     <= 1'b1;
    fetch_req_i.paddr <= addr;
    do begin
      @(posedge clk_i);
    end while (!fetch_ready_o);
    fetch_valid_i <= 1'b0;
  endtask

  task automatic wait_response();
    do begin
      @(posedge clk_i);
    end while (!rsp_valid_o);
  endtask

  task automatic fetch_hit(input logic [31:0] addr);
    int req_before;
    req_before = req_cnt;
    fetch_word(addr);
    @(posedge clk_i);
    if (rsp_valid_o !== 1'b1) begin
      $display("error %0t rsp_valid_o got %b expected 1", $time, rsp_valid_o);
      proto_err++;
    end
    // a hit leaves the fetch port open in its response cycle
    if (fetch_ready_o !== 1'b1) begin
      $display("error %0t fetch_ready_o got %b expected 1", $time, fetch_ready_o);
      proto_err++;
    end
    if (mem_req_o !== 1'b0 || req_cnt != req_before) begin
      $display("error %0t mem_req_o got %b expected 0 on a hit", $time, mem_req_o);
      proto_err++;
    end
  endtask

  task automatic fetch_cached_miss(input logic [31:0] addr);
    int req_before;
    int miss_before;
    req_before  = req_cnt;
    miss_before = miss_cnt;
    fetch_word(addr);
    // refill request one cycle after accept
    @(posedge clk_i);
    if (mem_req_o !== 1'b1) begin
      $display("error %0t mem_req_o got %b expected 1", $time, mem_req_o);
      proto_err++;
    end
    wait_response();
    if (req_cnt != req_before + 1) begin
      $display("error %0t refill count got %0d expected %0d", $time,
               req_cnt - req_before, 1);
      proto_err++;
    end
    if (last_req.paddr !== {addr[31:4], 4'b0000} || last_req.nc !== 1'b0) begin
      $display("error %0t mem_req_data_o got %h/%b expected %h/0", $time,
               last_req.paddr, last_req.nc, {addr[31:4], 4'b0000});
      proto_err++;
    end
    if (miss_cnt != miss_before + 1) begin
      $display("error %0t miss_o pulses got %0d expected 1", $time, miss_cnt - miss_before);
      proto_err++;
    end
  endtask

  task automatic fetch_uncached(input logic [31:0] addr);
    int req_before;
    int miss_before;
    req_before  = req_cnt;
    miss_before = miss_cnt;
    fetch_word(addr);
    wait_response();
    if (req_cnt != req_before + 1) begin
      $display("error %0t refill count got %0d expected %0d", $time,
               req_cnt - req_before, 1);
      proto_err++;
    end
    if (last_req.paddr !== {addr[31:2], 2'b00} || last_req.nc !== 1'b1) begin
      $display("error %0t mem_req_data_o got %h/%b expected %h/1", $time,
               last_req.paddr, last_req.nc, {addr[31:2], 2'b00});
      proto_err++;
    end
    if (miss_cnt != miss_before) begin
      $display("error %0t miss_o pulses got %0d expected 0", $time, miss_cnt - miss_before);
      proto_err++;
    end
  endtask

  task automatic finish_run(input logic timed_out);
    $display("errors: %0d data, %0d protocol; fetches %0d, responses %0d",
             data_err, proto_err, acc_cnt, rsp_cnt);
    if (data_err == 0 && proto_err == 0 && !timed_out) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////
  initial begin
    logic [31:0] line_a;
    logic [31:0] addr;
    int          line_idx;
    void'($urandom(32'hd02c));
    rst_ni         = 1'b0;
    en_i           = 1'b1;
    flush_i        = 1'b0;
    fetch_valid_i  = 1'b0;
    fetch_req_i    = '0;
    mem_ack_i      = 1'b0;
    mem_rtrn_vld_i = 1'b0;
    mem_rtrn_i     = '0;
    ack_wait       = -1;
    rtrn_wait      = 0;
    acc_cnt        = 0;
    rsp_cnt        = 0;
    req_cnt        = 0;
    miss_cnt       = 0;
    data_err       = 0;
    proto_err      = 0;
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    if (fetch_ready_o || rsp_valid_o || mem_req_o || miss_o) begin
      $display("error %0t: outputs active during the flush after reset", $time);
      proto_err++;
    end

    // cold miss, then the other words of the line hit
    line_a = 32'h0000_1230;
    fetch_cached_miss(line_a + 4);
    fetch_hit(line_a);
    fetch_hit(line_a + 8);
    fetch_hit(line_a + 12);

    // I/O space goes to memory every time
    fetch_uncached(32'h8000_0104);
    fetch_uncached(32'h8000_0104);

    // cache off, a cached line is fetched as single words
    en_i <= 1'b0;
    repeat (2) @(posedge clk_i);
    fetch_uncached(line_a + 8);
    fetch_uncached(line_a + 8);

    // enable goes through a flush, then fill, hit, flush and miss again
    en_i <= 1'b1;
    fetch_cached_miss(line_a);
    fetch_hit(line_a + 12);
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    fetch_cached_miss(line_a + 12);

    // six lines in each of sets 0 and 1, forces replacement
    for (int n = 0; n < NUM_RAND; n++) begin
      line_idx = $urandom_range(NUM_LINES - 1);
      addr = RAND_BASE + (line_idx / 2) * 32'h400 + (line_idx % 2) * 32'h10
             + $urandom_range(3) * 4;
      fetch_word(addr);
      if ($urandom_range(3) == 0) begin
        @(posedge clk_i);
      end
    end
    while (acc_q.size() != 0) begin
      @(posedge clk_i);
    end
    repeat (2) @(posedge clk_i);
    if (rsp_cnt != acc_cnt) begin
      $display("error %0t response count got %0d expected %0d", $time, rsp_cnt, acc_cnt);
      proto_err++;
    end
    finish_run(1'b0);
  end

  // run limit
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    finish_run(1'b1);
  end

endmodule

// File: flist.f
+incdir+verilog
verilog/icache_pkg.sv
verilog/icache_ctrl.sv
verilog/icache_lookup.sv
verilog/icache_arrays.sv
verilog/icache_top.sv
test/icache_tb.sv

// File: Bender.yml
package:
  name: icache

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/icache_pkg.sv
      - verilog/icache_ctrl.sv
      - verilog/icache_lookup.sv
      - verilog/icache_arrays.sv
      - verilog/icache_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - test/icache_tb.sv
